//--- sram_defs_pkg.sv
/* Geometry of the 16-bit asynchronous SRAM (1M halfwords, two byte lanes)
   and the state encoding of the access sequencer */
`default_nettype none

package sram_defs_pkg;

    // Data bus width of the SRAM part
    localparam int SRAM_DATA_WIDTH = 16;

    // Halfword address bits, 1M locations
    localparam int SRAM_ADDR_WIDTH = 20;

    // Lower and upper byte enable
    localparam int SRAM_BYTE_LANES = 2;

    // Size of the part in bytes, 2 MB
    localparam int SRAM_BYTE_SPAN = (2 ** SRAM_ADDR_WIDTH) * SRAM_BYTE_LANES;

    // Sequencer states
    // Gather states step through the halfwords of one Wishbone word,
    // ack states are the single cycle in which ack is high
    typedef enum logic [2:0] {
        SRAM_ST_IDLE      = 3'b000,
        SRAM_ST_RD_GATHER = 3'b001,
        SRAM_ST_RD_ACK    = 3'b010,
        SRAM_ST_WR_GATHER = 3'b011,
        SRAM_ST_WR_ACK    = 3'b100
    } sram_state_e;

endpackage

`default_nettype wire

//--- sram_phy.sv
/* SRAM pin driver and read assembler: address and byte enables per beat,
   tri-state data bus, and halfword capture into the Wishbone read word */
`default_nettype none

module sram_phy
    import sram_defs_pkg::*;
#(
    parameter int  OPTN_WB_DATA_WIDTH = 16,
    localparam int WB_SEL_WIDTH       = OPTN_WB_DATA_WIDTH / 8,
    localparam int GATHER_COUNT       = OPTN_WB_DATA_WIDTH / SRAM_DATA_WIDTH,
    localparam int GATHER_COUNT_WIDTH = (GATHER_COUNT == 1) ? 1 : $clog2(GATHER_COUNT)
) (
    input  logic                          i_wb_clk,
    input  logic                          i_wb_rst,
    input  sram_state_e                   i_state,
    input  logic [GATHER_COUNT_WIDTH-1:0] i_beat_idx,
    input  logic                          i_beat_we,
    input  logic                          i_cap_en,
    input  logic [SRAM_ADDR_WIDTH-1:0]    i_req_haddr,
    input  logic [WB_SEL_WIDTH-1:0]       i_req_sel,
    input  logic [OPTN_WB_DATA_WIDTH-1:0] i_req_wdata,
    output logic                          o_sram_ce_n,
    output logic                          o_sram_oe_n,
    output logic                          o_sram_we_n,
    output logic                          o_sram_lb_n,
    output logic                          o_sram_ub_n,
    output logic [SRAM_ADDR_WIDTH-1:0]    o_sram_addr,
    inout  wire  [SRAM_DATA_WIDTH-1:0]    io_sram_dq,
    output logic [OPTN_WB_DATA_WIDTH-1:0] o_wb_data
);

    localparam logic [GATHER_COUNT_WIDTH-1:0] LAST_BEAT = GATHER_COUNT_WIDTH'(GATHER_COUNT - 1);

    logic [SRAM_BYTE_LANES-1:0]    beat_sel;
    logic [SRAM_DATA_WIDTH-1:0]    beat_wdata;
    logic                          wr_phase;
    logic [OPTN_WB_DATA_WIDTH-1:0] asm_r;
    logic [OPTN_WB_DATA_WIDTH-1:0] rd_merge;

    // Little endian: beat 0 carries the lowest halfword and sel pair
    assign beat_sel   = i_req_sel[i_beat_idx*SRAM_BYTE_LANES +: SRAM_BYTE_LANES];
    assign beat_wdata = i_req_wdata[i_beat_idx*SRAM_DATA_WIDTH +: SRAM_DATA_WIDTH];
    assign wr_phase   = (i_state == SRAM_ST_WR_GATHER) || (i_state == SRAM_ST_WR_ACK);

    // Chip stays selected, OE only drops out to avoid bus contention on writes
    assign o_sram_ce_n = 1'b0;
    assign o_sram_oe_n = wr_phase;
    assign o_sram_we_n = ~i_beat_we;
    assign o_sram_lb_n = ~beat_sel[0];
    assign o_sram_ub_n = ~beat_sel[1];
    assign o_sram_addr = i_req_haddr + SRAM_ADDR_WIDTH'(i_beat_idx);

    // Drive DQ only under WE, released otherwise
    assign io_sram_dq = i_beat_we ? beat_wdata : {SRAM_DATA_WIDTH{1'bz}};

    // Earlier halfwords from the assembly register, current one from the pins
    always_comb begin
        rd_merge = asm_r;
        rd_merge[i_beat_idx*SRAM_DATA_WIDTH +: SRAM_DATA_WIDTH] = io_sram_dq;
    end

    always_ff @(posedge i_wb_clk) begin
        if (i_cap_en) asm_r <= rd_merge;
    end

    // Read word is loaded with the last halfword, valid through the ack cycle
    // and held until the next read completes
    always_ff @(posedge i_wb_clk) begin
        if (i_wb_rst) begin
            o_wb_data <= '0;
        end else if (i_cap_en && (i_beat_idx == LAST_BEAT)) begin
            o_wb_data <= rd_merge;
        end
    end

endmodule

`default_nettype wire

//--- sram_seq.sv
/* Access sequencer: gather FSM stepping through the halfword beats of a
   Wishbone word, with down-counter, beat index and registered ack */
`default_nettype none

module sram_seq
    import sram_defs_pkg::*;
#(
    parameter int  OPTN_WB_DATA_WIDTH = 16,
    localparam int GATHER_COUNT       = OPTN_WB_DATA_WIDTH / SRAM_DATA_WIDTH,
    localparam int GATHER_COUNT_WIDTH = (GATHER_COUNT == 1) ? 1 : $clog2(GATHER_COUNT)
) (
    input  logic                          i_wb_clk,
    input  logic                          i_wb_rst,
    input  logic                          i_req_valid,
    input  logic                          i_req_we,
    input  logic                          i_req_last,
    output sram_state_e                   o_state,
    output logic [GATHER_COUNT_WIDTH-1:0] o_beat_idx,
    output logic                          o_beat_we,
    output logic                          o_cap_en,
    output logic                          o_busy,
    output logic                          o_wb_ack
);

    // Remaining halfwords after the first one
    localparam logic [GATHER_COUNT_WIDTH-1:0] CNT_INIT = GATHER_COUNT_WIDTH'(GATHER_COUNT - 1);
    localparam logic [GATHER_COUNT_WIDTH-1:0] CNT_ONE  = GATHER_COUNT_WIDTH'(1);

    sram_state_e                   state_r;
    sram_state_e                   state_next;
    logic [GATHER_COUNT_WIDTH-1:0] cnt_r;
    logic [GATHER_COUNT_WIDTH-1:0] cnt_next;
    logic [GATHER_COUNT_WIDTH-1:0] idx_r;
    logic [GATHER_COUNT_WIDTH-1:0] idx_next;
    logic                          start;

    // Write: N-1 gather beats, last halfword goes out in the ack cycle
    // Read: N gather beats, each sampled at the end of its cycle, then ack
    // With a 16-bit bus the write gather state is never entered
    always_comb begin
        state_next = state_r;
        cnt_next   = cnt_r;
        idx_next   = idx_r;
        start      = 1'b0;

        case (state_r)
            SRAM_ST_IDLE: begin
                start = i_req_valid;
            end
            SRAM_ST_RD_GATHER: begin
                // Hold the index on the last beat so the ack cycle keeps it
                if (cnt_r == '0) begin
                    state_next = SRAM_ST_RD_ACK;
                end else begin
                    cnt_next = cnt_r - 1'b1;
                    idx_next = idx_r + 1'b1;
                end
            end
            SRAM_ST_WR_GATHER: begin
                cnt_next = cnt_r - 1'b1;
                idx_next = idx_r + 1'b1;
                if (cnt_r == CNT_ONE) state_next = SRAM_ST_WR_ACK;
            end
            SRAM_ST_RD_ACK, SRAM_ST_WR_ACK: begin
                // Non-last burst beat chains straight into the next word
                if (i_req_last) state_next = SRAM_ST_IDLE;
                else            start      = 1'b1;
            end
            default: begin
                state_next = SRAM_ST_IDLE;
            end
        endcase

        // First halfword of a new Wishbone word
        if (start) begin
            cnt_next = CNT_INIT;
            idx_next = '0;
            if (!i_req_we)             state_next = SRAM_ST_RD_GATHER;
            else if (GATHER_COUNT > 1) state_next = SRAM_ST_WR_GATHER;
            else                       state_next = SRAM_ST_WR_ACK;
        end
    end

    always_ff @(posedge i_wb_clk) begin
        if (i_wb_rst) begin
            state_r <= SRAM_ST_IDLE;
            cnt_r   <= '0;
            idx_r   <= '0;
        end else begin
            state_r <= state_next;
            cnt_r   <= cnt_next;
            idx_r   <= idx_next;
        end
    end

    // Ack is high exactly while the FSM sits in an ack state
    always_ff @(posedge i_wb_clk) begin
        if (i_wb_rst) begin
            o_wb_ack <= 1'b0;
        end else begin
            o_wb_ack <= (state_next == SRAM_ST_RD_ACK) || (state_next == SRAM_ST_WR_ACK);
        end
    end

    assign o_state    = state_r;
    assign o_beat_idx = idx_r;
    // WE stays low through the whole write, gather and ack alike
    assign o_beat_we  = (state_r == SRAM_ST_WR_GATHER) || (state_r == SRAM_ST_WR_ACK);
    // Every read gather cycle ends with a halfword sample
    assign o_cap_en   = (state_r == SRAM_ST_RD_GATHER);
    // Holds off err generation while a beat is in flight
    assign o_busy     = (state_r != SRAM_ST_IDLE);

endmodule

`default_nettype wire

//--- tb_clk_gen.sv
/* Testbench clock and synchronous reset source */
`default_nettype none

module tb_clk_gen #(
    parameter int RESET_CYCLES = 16
) (
    output logic o_clk,
    output logic o_rst
);
    timeunit 1ns;
    timeprecision 100ps;

    // 10 ns period, first rising edge at 5 ns
    initial begin
        o_clk = 1'b0;
        forever #5 o_clk = ~o_clk;
    end

    // Released just after an edge, like every other bench input
    initial begin
        o_rst = 1'b1;
        repeat (RESET_CYCLES) @(posedge o_clk);
        #1;
        o_rst = 1'b0;
    end

endmodule

`default_nettype wire

//--- tb_sram_model.sv
/* Behavioural asynchronous SRAM, 1M x 16 with lower and upper byte lanes,
   preloaded with an address-derived fill */
`default_nettype none

module tb_sram_model
    import sram_defs_pkg::*;
(
    input  wire                       i_ce_n,
    input  wire                       i_oe_n,
    input  wire                       i_we_n,
    input  wire                       i_lb_n,
    input  wire                       i_ub_n,
    input  wire [SRAM_ADDR_WIDTH-1:0] i_addr,
    inout  wire [SRAM_DATA_WIDTH-1:0] io_dq
);
    timeunit 1ns;
    timeprecision 100ps;

    logic [SRAM_DATA_WIDTH-1:0] mem [0:(2**SRAM_ADDR_WIDTH)-1];

    // Fill value of a halfword, every address bit takes part
    function automatic logic [15:0] fill_pattern(input logic [19:0] addr);
        return addr[15:0] ^ addr[19:4] ^ 16'h5ac3;
    endfunction

    initial begin
        for (int a = 0; a < 2 ** SRAM_ADDR_WIDTH; a++) begin
            mem[a] = fill_pattern(20'(a));
        end
    end

    // Read drive, never while WE is low
    assign io_dq = (!i_ce_n && !i_oe_n && i_we_n) ? mem[i_addr] : {SRAM_DATA_WIDTH{1'bz}};

    // Pins looked at half way between 1 ns steps, where a write has settled
    initial begin
        #0.5;
        forever begin
            if (!i_ce_n && !i_we_n) begin
                if (!i_lb_n) mem[i_addr][7:0] = io_dq[7:0];
                if (!i_ub_n) mem[i_addr][15:8] = io_dq[15:8];
            end
            #1;
        end
    end

endmodule

`default_nettype wire

//--- tb_wb_sram_top.sv
/* Testbench for the Wishbone SRAM slave: operation table, Wishbone master,
   shadow memory, response checks, watchdog and reporting */
`default_nettype none

module tb_wb_sram_top
    import wb_defs_pkg::*;
    import sram_defs_pkg::*;
();
    timeunit 1ns;
    timeprecision 100ps;

    localparam int          DATA_WIDTH   = 32;
    localparam int          ADDR_WIDTH   = 32;
    localparam logic [31:0] BASE_ADDR    = 32'h4000_0000;
    localparam int          GATHER       = DATA_WIDTH / SRAM_DATA_WIDTH;
    localparam int          NUM_OPS      = 15;
    localparam int          MAX_WAIT     = 16;
    localparam int          SHADOW_BYTES = 256;
    localparam int          WDOG_CYCLES  = NUM_OPS * 40;

    // One table row where exp is ack or the reason for err
    typedef struct packed {
        logic        we;
        logic [31:0] addr;
        logic [3:0]  sel;
        logic [31:0] data;
        logic        rand_data;
        logic [3:0]  blen;
        wb_err_e     exp;
    } op_t;

    logic        clk;
    logic        rst;
    logic        wb_cyc;
    logic        wb_stb;
    logic        wb_we;
    wb_cti_e     wb_cti;
    wb_bte_e     wb_bte;
    logic [3:0]  wb_sel;
    logic [31:0] wb_addr;
    logic [31:0] wb_wdata;
    logic [31:0] wb_rdata;
    logic        wb_ack;
    logic        wb_err;
    logic        sram_ce_n;
    logic        sram_oe_n;
    logic        sram_we_n;
    logic        sram_lb_n;
    logic        sram_ub_n;
    logic [19:0] sram_addr;
    wire  [15:0] sram_dq;

    op_t         ops [NUM_OPS];
    logic [7:0]  shadow [0:SHADOW_BYTES-1];
    logic [31:0] rng_state = 32'h233c_105c;
    int          errors = 0;
    int          checks = 0;

    tb_clk_gen u_clk_gen (
        .o_clk (clk),
        .o_rst (rst)
    );

    wb_sram_top #(
        .OPTN_WB_DATA_WIDTH (DATA_WIDTH),
        .OPTN_WB_ADDR_WIDTH (ADDR_WIDTH),
        .OPTN_BASE_ADDR     (BASE_ADDR)
    ) u_wb_sram_top (
        .i_wb_clk    (clk),
        .i_wb_rst    (rst),
        .i_wb_cyc    (wb_cyc),
        .i_wb_stb    (wb_stb),
        .i_wb_we     (wb_we),
        .i_wb_cti    (wb_cti),
        .i_wb_bte    (wb_bte),
        .i_wb_sel    (wb_sel),
        .i_wb_addr   (wb_addr),
        .i_wb_data   (wb_wdata),
        .o_wb_data   (wb_rdata),
        .o_wb_ack    (wb_ack),
        .o_wb_err    (wb_err),
        .o_sram_ce_n (sram_ce_n),
        .o_sram_oe_n (sram_oe_n),
        .o_sram_we_n (sram_we_n),
        .o_sram_lb_n (sram_lb_n),
        .o_sram_ub_n (sram_ub_n),
        .o_sram_addr (sram_addr),
        .io_sram_dq  (sram_dq)
    );

    tb_sram_model u_sram (
        .i_ce_n (sram_ce_n),
        .i_oe_n (sram_oe_n),
        .i_we_n (sram_we_n),
        .i_lb_n (sram_lb_n),
        .i_ub_n (sram_ub_n),
        .i_addr (sram_addr),
        .io_dq  (sram_dq)
    );

    // xorshift32
    function automatic logic [31:0] next_random();
        logic [31:0] x;
        x = rng_state;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        rng_state = x;
        return x;
    endfunction

    // Same fill as the SRAM model holds at start
    function automatic logic [15:0] fill_pattern(input logic [19:0] addr);
        return addr[15:0] ^ addr[19:4] ^ 16'h5ac3;
    endfunction

    function automatic op_t make_op(input logic we, input logic [31:0] addr,
                                    input logic [3:0] sel, input logic [31:0] data,
                                    input logic rand_data, input logic [3:0] blen,
                                    input wb_err_e exp);
        op_t op;
        op.we        = we;
        op.addr      = addr;
        op.sel       = sel;
        op.data      = data;
        op.rand_data = rand_data;
        op.blen      = blen;
        op.exp       = exp;
        return op;
    endfunction

    function automatic string outcome_text(input wb_err_e e);
        case (e)
            WB_ERR_WINDOW:    return "err outside window";
            WB_ERR_UNALIGNED: return "err unaligned";
            default:          return "ack";
        endcase
    endfunction

    task automatic check_value(input string name, input logic [63:0] got,
                               input logic [63:0] exp);
        checks++;
        if (got !== exp) begin
            $display("FAILED %s: got 0x%0h, expected 0x%0h", name, got, exp);
            errors++;
        end
    endtask

    task automatic load_table();
        ops[0]  = make_op(1'b1, BASE_ADDR + 32'h00, 4'hf, 32'h1234_5678, 1'b0, 4'd1, WB_ERR_NONE);
        ops[1]  = make_op(1'b0, BASE_ADDR + 32'h00, 4'hf, 32'h0, 1'b0, 4'd1, WB_ERR_NONE);
        // Partial writes over a full random word
        ops[2]  = make_op(1'b1, BASE_ADDR + 32'h04, 4'hf, 32'h0, 1'b1, 4'd1, WB_ERR_NONE);
        ops[3]  = make_op(1'b1, BASE_ADDR + 32'h04, 4'b0001, 32'h0, 1'b1, 4'd1, WB_ERR_NONE);
        ops[4]  = make_op(1'b1, BASE_ADDR + 32'h04, 4'b0110, 32'h0, 1'b1, 4'd1, WB_ERR_NONE);
        ops[5]  = make_op(1'b1, BASE_ADDR + 32'h04, 4'b1000, 32'h0, 1'b1, 4'd1, WB_ERR_NONE);
        ops[6]  = make_op(1'b0, BASE_ADDR + 32'h04, 4'hf, 32'h0, 1'b0, 4'd1, WB_ERR_NONE);
        // Four-beat incrementing bursts
        ops[7]  = make_op(1'b1, BASE_ADDR + 32'h20, 4'hf, 32'h0, 1'b1, 4'd4, WB_ERR_NONE);
        ops[8]  = make_op(1'b0, BASE_ADDR + 32'h20, 4'hf, 32'h0, 1'b0, 4'd4, WB_ERR_NONE);
        // Refused beats
        // The first one would alias halfword 0 if it got through
        ops[9]  = make_op(1'b1, BASE_ADDR + 32'h20_0000, 4'hf, 32'hdead_beef, 1'b0, 4'd1,
                          WB_ERR_WINDOW);
        ops[10] = make_op(1'b1, BASE_ADDR - 32'h4, 4'hf, 32'hdead_beef, 1'b0, 4'd1, WB_ERR_WINDOW);
        ops[11] = make_op(1'b1, BASE_ADDR + 32'h11, 4'hf, 32'hdead_beef, 1'b0, 4'd1,
                          WB_ERR_UNALIGNED);
        ops[12] = make_op(1'b0, BASE_ADDR + 32'h23, 4'hf, 32'h0, 1'b0, 4'd1, WB_ERR_UNALIGNED);
        // Memory behind the refused beats is untouched
        ops[13] = make_op(1'b0, BASE_ADDR + 32'h00, 4'hf, 32'h0, 1'b0, 4'd1, WB_ERR_NONE);
        ops[14] = make_op(1'b0, BASE_ADDR + 32'h10, 4'hf, 32'h0, 1'b0, 4'd2, WB_ERR_NONE);
    endtask

    task automatic init_shadow();
        logic [15:0] h;
        for (int off = 0; off < SHADOW_BYTES; off++) begin
            h = fill_pattern(20'(off >> 1));
            shadow[off] = (off % 2 == 1) ? h[15:8] : h[7:0];
        end
    endtask

    task automatic shadow_write(input logic [31:0] addr, input logic [3:0] sel,
                                input logic [31:0] data);
        int off;
        off = int'(addr - BASE_ADDR);
        for (int i = 0; i < 4; i++) begin
            if (sel[i] && off + i < SHADOW_BYTES) shadow[off + i] = data[8*i +: 8];
        end
    endtask

    function automatic logic [31:0] shadow_word(input logic [31:0] addr);
        int off;
        off = int'(addr - BASE_ADDR);
        return {shadow[off + 3], shadow[off + 2], shadow[off + 1], shadow[off]};
    endfunction

    // Counts rising edges from the drive point up to the response,
    // sampled at the falling edge
    // WE and OE follow the expected access, a refused beat strobes nothing
    task automatic wait_response(input logic exp_write, output logic got_ack,
                                 output logic got_err, output int cycles);
        cycles  = 0;
        got_ack = 1'b0;
        got_err = 1'b0;
        // The previous response has ended before this beat is taken
        @(negedge clk);
        check_value("o_wb_ack", wb_ack, 1'b0);
        check_value("o_wb_err", wb_err, 1'b0);
        while (!got_ack && !got_err && cycles < MAX_WAIT) begin
            @(posedge clk);
            cycles++;
            @(negedge clk);
            got_ack = wb_ack;
            got_err = wb_err;
            check_value("o_sram_we_n", sram_we_n, !exp_write);
            check_value("o_sram_oe_n", sram_oe_n, exp_write);
        end
        if (!got_ack && !got_err) begin
            $display("no ack or err from the DUT within %0d cycles", MAX_WAIT);
            errors++;
        end
    endtask

    // Entered 1 ns after a rising edge, leaves at the same point
    task automatic run_op(input int n);
        op_t         op;
        int          errors_before;
        int          cycles;
        int          exp_cycles;
        logic        got_ack;
        logic        got_err;
        logic        ok;
        logic [31:0] addr;
        logic [31:0] wdata;
        op = ops[n];
        errors_before = errors;
        ok = (op.exp == WB_ERR_NONE);
        for (int b = 0; b < op.blen; b++) begin
            addr  = op.addr + 32'(4 * b);
            wdata = op.rand_data ? next_random() : op.data;
            wb_cyc   = 1'b1;
            wb_stb   = 1'b1;
            wb_we    = op.we;
            wb_addr  = addr;
            wb_sel   = op.sel;
            wb_wdata = wdata;
            if (op.blen == 1) wb_cti = WB_CTI_CLASSIC;
            else if (b == op.blen - 1) wb_cti = WB_CTI_EOB;
            else wb_cti = WB_CTI_INCR;
            // Write N, read N+1, err 1; later burst beats count from the
            // previous ack, one edge before this drive point
            if (!ok) exp_cycles = 1;
            else exp_cycles = (op.we ? GATHER : GATHER + 1) - ((b > 0) ? 1 : 0);
            wait_response(ok && op.we, got_ack, got_err, cycles);
            check_value("o_wb_ack", got_ack, ok);
            check_value("o_wb_err", got_err, !ok);
            check_value("response latency", cycles, exp_cycles);
            if (ok && op.we) shadow_write(addr, op.sel, wdata);
            if (ok && !op.we && got_ack) check_value("o_wb_data", wb_rdata, shadow_word(addr));
            @(posedge clk);
            #1;
        end
        wb_cyc = 1'b0;
        wb_stb = 1'b0;
        wb_we  = 1'b0;
        wb_cti = WB_CTI_CLASSIC;
        // Responses last one cycle only
        @(negedge clk);
        check_value("o_wb_ack", wb_ack, 1'b0);
        check_value("o_wb_err", wb_err, 1'b0);
        $display("test %0d: %s addr 0x%h beats %0d, %s: %s", n, op.we ? "write" : "read",
                 op.addr, op.blen, outcome_text(op.exp),
                 (errors == errors_before) ? "ok" : "failed");
        @(posedge clk);
        #1;
    endtask

    initial begin
        wb_cyc   = 1'b0;
        wb_stb   = 1'b0;
        wb_we    = 1'b0;
        wb_cti   = WB_CTI_CLASSIC;
        wb_bte   = WB_BTE_LINEAR;
        wb_sel   = 4'h0;
        wb_addr  = BASE_ADDR;
        wb_wdata = 32'h0;
        load_table();
        init_shadow();
        @(negedge rst);
        @(negedge clk);
        // Idle pins with the SRAM driving halfword 0 onto a released bus
        check_value("o_wb_ack", wb_ack, 1'b0);
        check_value("o_wb_err", wb_err, 1'b0);
        check_value("o_sram_we_n", sram_we_n, 1'b1);
        check_value("o_sram_ce_n", sram_ce_n, 1'b0);
        check_value("o_sram_oe_n", sram_oe_n, 1'b0);
        check_value("io_sram_dq", sram_dq, fill_pattern(20'h0));
        $display("reset state: %s", (errors == 0) ? "ok" : "failed");
        @(posedge clk);
        #1;
        for (int n = 0; n < NUM_OPS; n++) begin
            run_op(n);
        end
        $display("tests %0d, checks %0d, errors %0d", NUM_OPS, checks, errors);
        if (errors == 0) begin
            $display("TB PASSED");
        end else begin
            $display("TB FAILED");
        end
        $finish;
    end

    initial begin
        repeat (WDOG_CYCLES) @(posedge clk);
        $display("watchdog expired after %0d cycles, the run did not finish", WDOG_CYCLES);
        $display("TB FAILED");
        $finish;
    end

endmodule

`default_nettype wire

//--- wb_defs_pkg.sv
/* Wishbone B4 encodings used by the SRAM slave:
   cycle type, burst type and refused-access reason */
`default_nettype none

package wb_defs_pkg;

    // Cycle type identifier, CTI_I
    // Reserved codes 011 to 110 are handled like classic cycles
    typedef enum logic [2:0] {
        WB_CTI_CLASSIC  = 3'b000,
        WB_CTI_CONSTANT = 3'b001,
        WB_CTI_INCR     = 3'b010,
        WB_CTI_EOB      = 3'b111
    } wb_cti_e;

    // Burst type extension, BTE_I
    // Only linear addressing is implemented, wrap codes run linear
    typedef enum logic [1:0] {
        WB_BTE_LINEAR = 2'b00,
        WB_BTE_4BEAT  = 2'b01,
        WB_BTE_8BEAT  = 2'b10,
        WB_BTE_16BEAT = 2'b11
    } wb_bte_e;

    // Why a beat was answered with err instead of ack
    typedef enum logic [1:0] {
        WB_ERR_NONE      = 2'b00,
        WB_ERR_WINDOW    = 2'b01,
        WB_ERR_UNALIGNED = 2'b10
    } wb_err_e;

endpackage

`default_nettype wire

//--- wb_sram_req.sv
/* Wishbone request decoder: beat qualification, address window and
   alignment check, halfword address and registered error acknowledge */
`default_nettype none

module wb_sram_req
    import wb_defs_pkg::*;
    import sram_defs_pkg::*;
#(
    parameter int                            OPTN_WB_DATA_WIDTH = 16,
    parameter int                            OPTN_WB_ADDR_WIDTH = 32,
    parameter logic [OPTN_WB_ADDR_WIDTH-1:0] OPTN_BASE_ADDR     = '0,
    localparam int                           WB_SEL_WIDTH       = OPTN_WB_DATA_WIDTH / 8
) (
    input  logic                          i_wb_clk,
    input  logic                          i_wb_rst,
    input  logic                          i_wb_cyc,
    input  logic                          i_wb_stb,
    input  logic                          i_wb_we,
    input  wb_cti_e                       i_wb_cti,
    // Wrapping bursts are run as linear ones, so BTE is not decoded
    input  wb_bte_e                       i_wb_bte,
    input  logic [WB_SEL_WIDTH-1:0]       i_wb_sel,
    input  logic [OPTN_WB_ADDR_WIDTH-1:0] i_wb_addr,
    input  logic [OPTN_WB_DATA_WIDTH-1:0] i_wb_data,
    input  logic                          i_busy,
    output logic                          o_req_valid,
    output logic                          o_req_we,
    output logic                          o_req_last,
    output logic [SRAM_ADDR_WIDTH-1:0]    o_req_haddr,
    output logic [WB_SEL_WIDTH-1:0]       o_req_sel,
    output logic [OPTN_WB_DATA_WIDTH-1:0] o_req_wdata,
    output logic                          o_wb_err
);

    // One bit wider than the bus address so a borrow lands above the span
    localparam logic [OPTN_WB_ADDR_WIDTH:0] WINDOW_SPAN = (OPTN_WB_ADDR_WIDTH + 1)'(SRAM_BYTE_SPAN);

    logic                        cyc_stb;
    logic [OPTN_WB_ADDR_WIDTH:0] offset;
    logic                        in_window;
    logic                        unaligned;
    wb_err_e                     err_reason;
    wb_err_e                     err_reason_r;

    assign cyc_stb = i_wb_cyc && i_wb_stb;

    // Byte offset into the window
    // Addresses below the base wrap to a huge value and fail the span test
    assign offset    = {1'b0, i_wb_addr} - {1'b0, OPTN_BASE_ADDR};
    assign in_window = offset < WINDOW_SPAN;
    assign unaligned = i_wb_addr[0];

    always_comb begin
        if (!in_window)     err_reason = WB_ERR_WINDOW;
        else if (unaligned) err_reason = WB_ERR_UNALIGNED;
        else                err_reason = WB_ERR_NONE;
    end

    // Only clean beats reach the sequencer
    assign o_req_valid = cyc_stb && (err_reason == WB_ERR_NONE);
    assign o_req_we    = i_wb_we;
    // Anything but an incrementing beat closes the transfer
    assign o_req_last  = (i_wb_cti != WB_CTI_INCR);
    assign o_req_haddr = offset[SRAM_ADDR_WIDTH:1];
    assign o_req_sel   = i_wb_sel;
    assign o_req_wdata = i_wb_data;

    // Err is a one-cycle pulse; the master still holds the refused beat
    // in the err cycle, so the pulse itself blocks a repeat
    always_ff @(posedge i_wb_clk) begin
        if (i_wb_rst) begin
            o_wb_err     <= 1'b0;
            err_reason_r <= WB_ERR_NONE;
        end else begin
            o_wb_err <= cyc_stb && (err_reason != WB_ERR_NONE) && !o_wb_err && !i_busy;
            // Last refusal cause, visible in waveforms
            if (cyc_stb && (err_reason != WB_ERR_NONE) && !o_wb_err && !i_busy) begin
                err_reason_r <= err_reason;
            end
        end
    end

endmodule

`default_nettype wire

//--- wb_sram_top.f
wb_defs_pkg.sv
sram_defs_pkg.sv
wb_sram_req.sv
sram_seq.sv
sram_phy.sv
wb_sram_top.sv
tb_clk_gen.sv
tb_sram_model.sv
tb_wb_sram_top.sv

//--- wb_sram_top.sv
/* Wishbone B4 slave for a 16-bit asynchronous SRAM: request decoder,
   access sequencer and pin driver */
`default_nettype none

module wb_sram_top
    import wb_defs_pkg::*;
    import sram_defs_pkg::*;
#(
    parameter int                            OPTN_WB_DATA_WIDTH = 16,
    parameter int                            OPTN_WB_ADDR_WIDTH = 32,
    parameter logic [OPTN_WB_ADDR_WIDTH-1:0] OPTN_BASE_ADDR     = '0,
    localparam int                           WB_SEL_WIDTH       = OPTN_WB_DATA_WIDTH / 8,
    localparam int                           GATHER_COUNT       = OPTN_WB_DATA_WIDTH / SRAM_DATA_WIDTH
) (
    // Wishbone slave
    input  logic                          i_wb_clk,
    input  logic                          i_wb_rst,
    input  logic                          i_wb_cyc,
    input  logic                          i_wb_stb,
    input  logic                          i_wb_we,
    input  wb_cti_e                       i_wb_cti,
    input  wb_bte_e                       i_wb_bte,
    input  logic [WB_SEL_WIDTH-1:0]       i_wb_sel,
    input  logic [OPTN_WB_ADDR_WIDTH-1:0] i_wb_addr,
    input  logic [OPTN_WB_DATA_WIDTH-1:0] i_wb_data,
    output logic [OPTN_WB_DATA_WIDTH-1:0] o_wb_data,
    output logic                          o_wb_ack,
    output logic                          o_wb_err,

    // SRAM pins
    output logic                          o_sram_ce_n,
    output logic                          o_sram_oe_n,
    output logic                          o_sram_we_n,
    output logic                          o_sram_lb_n,
    output logic                          o_sram_ub_n,
    output logic [SRAM_ADDR_WIDTH-1:0]    o_sram_addr,
    inout  wire  [SRAM_DATA_WIDTH-1:0]    io_sram_dq
);

    localparam int GATHER_COUNT_WIDTH = (GATHER_COUNT == 1) ? 1 : $clog2(GATHER_COUNT);

    // Decoder to sequencer and pin driver
    logic                          req_valid;
    logic                          req_we;
    logic                          req_last;
    logic [SRAM_ADDR_WIDTH-1:0]    req_haddr;
    logic [WB_SEL_WIDTH-1:0]       req_sel;
    logic [OPTN_WB_DATA_WIDTH-1:0] req_wdata;

    // Sequencer to pin driver and decoder
    sram_state_e                   seq_state;
    logic [GATHER_COUNT_WIDTH-1:0] beat_idx;
    logic                          beat_we;
    logic                          cap_en;
    logic                          seq_busy;

    wb_sram_req #(
        .OPTN_WB_DATA_WIDTH (OPTN_WB_DATA_WIDTH),
        .OPTN_WB_ADDR_WIDTH (OPTN_WB_ADDR_WIDTH),
        .OPTN_BASE_ADDR     (OPTN_BASE_ADDR)
    ) u_req (
        .i_wb_clk    (i_wb_clk),
        .i_wb_rst    (i_wb_rst),
        .i_wb_cyc    (i_wb_cyc),
        .i_wb_stb    (i_wb_stb),
        .i_wb_we     (i_wb_we),
        .i_wb_cti    (i_wb_cti),
        .i_wb_bte    (i_wb_bte),
        .i_wb_sel    (i_wb_sel),
        .i_wb_addr   (i_wb_addr),
        .i_wb_data   (i_wb_data),
        .i_busy      (seq_busy),
        .o_req_valid (req_valid),
        .o_req_we    (req_we),
        .o_req_last  (req_last),
        .o_req_haddr (req_haddr),
        .o_req_sel   (req_sel),
        .o_req_wdata (req_wdata),
        .o_wb_err    (o_wb_err)
    );

    sram_seq #(
        .OPTN_WB_DATA_WIDTH (OPTN_WB_DATA_WIDTH)
    ) u_seq (
        .i_wb_clk    (i_wb_clk),
        .i_wb_rst    (i_wb_rst),
        .i_req_valid (req_valid),
        .i_req_we    (req_we),
        .i_req_last  (req_last),
        .o_state     (seq_state),
        .o_beat_idx  (beat_idx),
        .o_beat_we   (beat_we),
        .o_cap_en    (cap_en),
        .o_busy      (seq_busy),
        .o_wb_ack    (o_wb_ack)
    );

    sram_phy #(
        .OPTN_WB_DATA_WIDTH (OPTN_WB_DATA_WIDTH)
    ) u_phy (
        .i_wb_clk    (i_wb_clk),
        .i_wb_rst    (i_wb_rst),
        .i_state     (seq_state),
        .i_beat_idx  (beat_idx),
        .i_beat_we   (beat_we),
        .i_cap_en    (cap_en),
        .i_req_haddr (req_haddr),
        .i_req_sel   (req_sel),
        .i_req_wdata (req_wdata),
        .o_sram_ce_n (o_sram_ce_n),
        .o_sram_oe_n (o_sram_oe_n),
        .o_sram_we_n (o_sram_we_n),
        .o_sram_lb_n (o_sram_lb_n),
        .o_sram_ub_n (o_sram_ub_n),
        .o_sram_addr (o_sram_addr),
        .io_sram_dq  (io_sram_dq),
        .o_wb_data   (o_wb_data)
    );

endmodule

`default_nettype wire
